// File: common/chip_port_params.svh
// widths, depths and memory timing of the chip port bridge
// included by the package and by every module that sizes a port from it
`ifndef CHIP_PORT_PARAMS_SVH
`define CHIP_PORT_PARAMS_SVH

// one chip port word
`define CP_WORD_W 64

// word address carried in the command word
`define CP_ADDR_W 12

// bus byte address width
`define CP_HADDR_W 32

// entries in each buffering fifo
`define CP_FIFO_DEPTH 4

// wait states the board memory adds to every transfer
`define CP_MEM_WAIT 1

`endif

// File: common/chip_port_pkg.sv
// shared types of the chip port bridge
// modules pull these in with a wildcard import in their header
`include "chip_port_params.svh"

package chip_port_pkg;

    // direction bit sits at the bottom, start address right above it
    localparam int CMD_ADDR_LSB = 1;

    typedef logic [`CP_WORD_W-1:0] word_t;
    typedef logic [`CP_ADDR_W-1:0] addr_t;

    // bit 0 of the command word
    typedef enum logic {
        DIR_TO_CHIP = 1'b0,
        DIR_TO_MEM  = 1'b1
    } cmd_dir_e;

    // controller fsm
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CMD,
        ST_TO_CHIP,
        ST_TO_MEM,
        ST_DRAIN
    } itf_state_e;

    // ahb transfer codes, busy is never issued
    typedef enum logic [1:0] {
        HT_IDLE   = 2'b00,
        HT_NONSEQ = 2'b10,
        HT_SEQ    = 2'b11
    } htrans_e;

    // one write beat, tagged with its word address
    typedef struct packed {
        addr_t addr;
        word_t data;
    } wr_beat_t;

    function automatic cmd_dir_e cmd_dir(input word_t cmd);
        return cmd_dir_e'(cmd[0]);
    endfunction

    function automatic addr_t cmd_addr(input word_t cmd);
        return cmd[CMD_ADDR_LSB +: `CP_ADDR_W];
    endfunction

endpackage

// File: filelist.f
+incdir+common
+incdir+test
common/chip_port_pkg.sv
hw/chip_itf/chip_fifo.sv
hw/chip_itf/chip_itf_ctrl.sv
hw/board_mem/ahb_word_mem.sv
hw/chip_bridge_top.sv
test/tb_chip_bridge.sv

// File: hw/board_mem/ahb_word_mem.sv
// ahb-lite slave word memory, stands in for board ddr
// adds fixed wait states per transfer and errors on bad addresses
`include "chip_port_params.svh"

module ahb_word_mem
    import chip_port_pkg::*;
#(
    parameter int MEM_WORDS   = 1 << `CP_ADDR_W,
    parameter int WAIT_STATES = `CP_MEM_WAIT
)(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`CP_HADDR_W-1:0]  i_haddr,
    input  htrans_e                 i_htrans,
    input  logic                    i_hwrite,
    input  word_t                   i_hwdata,
    output word_t                   o_hrdata,
    output logic                    o_hready,
    output logic                    o_hresp
);

    localparam int IDX_W    = $clog2(MEM_WORDS);
    // an error needs at least one low hready cycle
    localparam int ERR_WAIT = (WAIT_STATES > 1) ? WAIT_STATES : 1;
    localparam int WAIT_W   = $clog2(ERR_WAIT + 1);

    word_t                  mem [MEM_WORDS];
    logic                   ph_valid_q;
    logic                   ph_write_q;
    logic                   ph_err_q;
    logic [IDX_W-1:0]       ph_idx_q;
    logic [WAIT_W-1:0]      wait_q;
    logic [`CP_HADDR_W-4:0] word_addr;
    logic                   addr_bad;
    logic                   ap_take;
    logic                   ph_done;

    assign word_addr = i_haddr[`CP_HADDR_W-1:3];
    // misaligned or past the end of the array
    assign addr_bad  = (i_haddr[2:0] != 3'b000)
                     || ({3'b000, word_addr} >= `CP_HADDR_W'(MEM_WORDS));

    assign o_hready = ~ph_valid_q | (wait_q == '0);
    assign ph_done  = ph_valid_q & (wait_q == '0);
    assign ap_take  = o_hready & ((i_htrans == HT_NONSEQ) || (i_htrans == HT_SEQ));

    // two-cycle error, last wait cycle and the completing one
    assign o_hresp  = ph_valid_q & ph_err_q & (wait_q <= WAIT_W'(1));
    assign o_hrdata = (ph_valid_q && !ph_err_q) ? mem[ph_idx_q] : '0;

    // ==================================================
    // address phase capture and wait counter
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ph_valid_q <= 1'b0;
            ph_write_q <= 1'b0;
            ph_err_q   <= 1'b0;
            ph_idx_q   <= '0;
            wait_q     <= '0;
        end else if (ap_take) begin
            ph_valid_q <= 1'b1;
            ph_write_q <= i_hwrite;
            ph_err_q   <= addr_bad;
            ph_idx_q   <= word_addr[IDX_W-1:0];
            wait_q     <= addr_bad ? WAIT_W'(ERR_WAIT) : WAIT_W'(WAIT_STATES);
        end else if (ph_done) begin
            ph_valid_q <= 1'b0;
        end else if (ph_valid_q) begin
            // hready low for this cycle
            wait_q <= wait_q - 1'b1;
        end
    end

    // ==================================================
    // word array
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (ph_done && ph_write_q && !ph_err_q) begin
            // hwdata is valid on the completing cycle
            mem[ph_idx_q] <= i_hwdata;
        end
    end

endmodule

// File: hw/chip_bridge_top.sv
// chip-facing bridge of the test board
// controller, write and read fifos, and the board memory
`include "chip_port_params.svh"

module chip_bridge_top
    import chip_port_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   i_cmd_vld,
    input  logic   i_dat_oe,
    input  word_t  i_dat,
    input  logic   i_dat_vld,
    output logic   o_dat_rdy,
    output word_t  o_dat,
    output logic   o_dat_vld,
    input  logic   i_dat_rdy
);

    localparam int CNT_W = $clog2(`CP_FIFO_DEPTH + 1);

    // write path
    logic                    wr_push, wr_full, wr_pop, wr_empty;
    wr_beat_t                wr_beat, wr_front;
    // read path
    logic                    rd_push, rd_full, rd_empty, rd_flush, rd_pop;
    word_t                   rd_word;
    logic [CNT_W-1:0]        rd_count;
    // ahb
    logic [`CP_HADDR_W-1:0]  haddr;
    htrans_e                 htrans;
    logic                    hwrite, hready, hresp;
    word_t                   hwdata, hrdata;

    // chip takes a word whenever the head is valid and it is ready
    assign rd_pop    = i_dat_rdy & ~rd_empty;
    assign o_dat_vld = ~rd_empty;

    chip_itf_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_cmd_vld     (i_cmd_vld),
        .i_dat_oe      (i_dat_oe),
        .i_dat         (i_dat),
        .i_dat_vld     (i_dat_vld),
        .o_dat_rdy     (o_dat_rdy),
        .o_wr_push     (wr_push),
        .o_wr_beat     (wr_beat),
        .i_wr_full     (wr_full),
        .o_wr_pop      (wr_pop),
        .i_wr_empty    (wr_empty),
        .i_wr_front    (wr_front),
        .o_rd_push     (rd_push),
        .o_rd_word     (rd_word),
        .i_rd_full     (rd_full),
        .i_rd_count    (rd_count),
        .o_rd_flush    (rd_flush),
        .i_dat_rdy_pop (rd_pop),
        .o_haddr       (haddr),
        .o_htrans      (htrans),
        .o_hwrite      (hwrite),
        .o_hwdata      (hwdata),
        .i_hrdata      (hrdata),
        .i_hready      (hready),
        .i_hresp       (hresp)
    );

    chip_fifo #(.T(wr_beat_t), .DEPTH(`CP_FIFO_DEPTH)) u_wr_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_push  (wr_push),
        .i_data  (wr_beat),
        .o_full  (wr_full),
        .i_pop   (wr_pop),
        .o_data  (wr_front),
        .o_empty (wr_empty),
        .o_count (),
        .i_flush (1'b0)
    );

    chip_fifo #(.T(word_t), .DEPTH(`CP_FIFO_DEPTH)) u_rd_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_push  (rd_push),
        .i_data  (rd_word),
        .o_full  (rd_full),
        .i_pop   (rd_pop),
        .o_data  (o_dat),
        .o_empty (rd_empty),
        .o_count (rd_count),
        .i_flush (rd_flush)
    );

    ahb_word_mem u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_haddr  (haddr),
        .i_htrans (htrans),
        .i_hwrite (hwrite),
        .i_hwdata (hwdata),
        .o_hrdata (hrdata),
        .o_hready (hready),
        .o_hresp  (hresp)
    );

endmodule

// File: hw/chip_itf/chip_fifo.sv
// small synchronous fifo, payload type set per instance
// buffers write beats toward memory and read words toward the chip
`include "chip_port_params.svh"

module chip_fifo
    import chip_port_pkg::*;
#(
    parameter type T     = word_t,
    parameter int  DEPTH = `CP_FIFO_DEPTH
)(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_push,
    input  T                             i_data,
    output logic                         o_full,
    input  logic                         i_pop,
    output T                             o_data,
    output logic                         o_empty,
    output logic [$clog2(DEPTH+1)-1:0]   o_count,
    input  logic                         i_flush
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T                           mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;
    logic                       do_push;
    logic                       do_pop;

    assign o_full  = (count_q == DEPTH[$clog2(DEPTH+1)-1:0]);
    assign o_empty = (count_q == '0);
    assign o_count = count_q;
    assign o_data  = mem[rd_ptr_q];

    // guard against overrun and underrun
    assign do_push = i_push & ~o_full;
    assign do_pop  = i_pop & ~o_empty;

    // ==================================================
    // pointers and occupancy
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (i_flush) begin
            // drop everything in one cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // push plus pop leaves the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= i_data;
        end
    end

endmodule

// File: hw/chip_itf/chip_itf_ctrl.sv
// chip port controller, turns chip commands into ahb-lite bursts
// buffers writes through one fifo and prefetches reads into another
`include "chip_port_params.svh"

module chip_itf_ctrl
    import chip_port_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst_n,
    // chip side
    input  logic                                   i_cmd_vld,
    input  logic                                   i_dat_oe,
    input  word_t                                  i_dat,
    input  logic                                   i_dat_vld,
    output logic                                   o_dat_rdy,
    // write fifo
    output logic                                   o_wr_push,
    output wr_beat_t                               o_wr_beat,
    input  logic                                   i_wr_full,
    output logic                                   o_wr_pop,
    input  logic                                   i_wr_empty,
    input  wr_beat_t                               i_wr_front,
    // read fifo
    output logic                                   o_rd_push,
    output word_t                                  o_rd_word,
    input  logic                                   i_rd_full,
    input  logic [$clog2(`CP_FIFO_DEPTH+1)-1:0]    i_rd_count,
    output logic                                   o_rd_flush,
    input  logic                                   i_dat_rdy_pop,
    // ahb master
    output logic [`CP_HADDR_W-1:0]                 o_haddr,
    output htrans_e                                o_htrans,
    output logic                                   o_hwrite,
    output word_t                                  o_hwdata,
    input  word_t                                  i_hrdata,
    input  logic                                   i_hready,
    input  logic                                   i_hresp
);

    localparam int CNT_W = $clog2(`CP_FIFO_DEPTH + 1);

    itf_state_e      state_q, state_d;
    addr_t           addr_q;
    logic            first_q;
    // address phase, held until the slave takes it
    logic            ap_valid_q, ap_write_q, ap_keep_q, ap_seq_q;
    addr_t           ap_addr_q;
    word_t           ap_wdata_q;
    // data phase
    logic            dp_valid_q, dp_write_q, dp_keep_q;
    word_t           hwdata_q;
    logic            cmd_acc, wr_acc, rd_end, ap_free, dp_done, drain_done;
    logic            wr_issue, rd_issue;
    logic [1:0]      rd_inflight;
    logic [CNT_W:0]  rd_free;

    assign cmd_acc = (state_q == ST_CMD) & i_dat_oe & i_dat_vld;
    assign wr_acc  = (state_q == ST_TO_MEM) & i_dat_oe & i_dat_vld & ~i_wr_full;
    // a read ends at once, stale beats are thrown away
    assign rd_end  = (state_q == ST_TO_CHIP) & i_cmd_vld;
    assign ap_free = ~ap_valid_q | i_hready;
    assign dp_done = dp_valid_q & i_hready;
    assign drain_done = i_wr_empty & ~ap_valid_q & (~dp_valid_q | i_hready);

    // reads still owed to the fifo
    assign rd_inflight = {1'b0, ap_valid_q & ~ap_write_q & ap_keep_q}
                       + {1'b0, dp_valid_q & ~dp_write_q & dp_keep_q};
    assign rd_free = (CNT_W+1)'(`CP_FIFO_DEPTH) - {1'b0, i_rd_count}
                   + {{CNT_W{1'b0}}, i_dat_rdy_pop};

    // writes go first, the write fifo is empty during reads anyway
    assign wr_issue = ~i_wr_empty & ap_free;
    assign rd_issue = (state_q == ST_TO_CHIP) & ~rd_end & ap_free
                    & (rd_free > {{(CNT_W-1){1'b0}}, rd_inflight});

    // ==================================================
    // command fsm
    // ==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:    if (i_cmd_vld) state_d = ST_CMD;
            ST_CMD: begin
                if (cmd_acc) begin
                    state_d = (cmd_dir(i_dat) == DIR_TO_MEM) ? ST_TO_MEM : ST_TO_CHIP;
                end
            end
            ST_TO_CHIP: if (i_cmd_vld) state_d = ST_IDLE;
            ST_TO_MEM:  if (i_cmd_vld) state_d = ST_DRAIN;
            ST_DRAIN:   if (drain_done) state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            addr_q  <= '0;
            first_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // word address, one step per write word or issued read
            if (cmd_acc) begin
                addr_q <= cmd_addr(i_dat);
            end else if (wr_acc || rd_issue) begin
                addr_q <= addr_q + 1'b1;
            end
            if (cmd_acc) begin
                first_q <= 1'b1;
            end else if (wr_issue || rd_issue) begin
                first_q <= 1'b0;
            end
        end
    end

    // ==================================================
    // ahb address and data pipeline
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ap_valid_q <= 1'b0;
            ap_write_q <= 1'b0;
            ap_keep_q  <= 1'b0;
            ap_seq_q   <= 1'b0;
            dp_valid_q <= 1'b0;
            dp_write_q <= 1'b0;
            dp_keep_q  <= 1'b0;
        end else begin
            if (wr_issue || rd_issue) begin
                ap_valid_q <= 1'b1;
                ap_write_q <= wr_issue;
                ap_keep_q  <= 1'b1;
                ap_seq_q   <= ~first_q;
            end else if (ap_free) begin
                ap_valid_q <= 1'b0;
            end else if (rd_end) begin
                // held phase still runs on the bus, result dropped
                ap_keep_q <= 1'b0;
            end
            if (i_hready) begin
                dp_valid_q <= ap_valid_q;
                dp_write_q <= ap_write_q;
                dp_keep_q  <= ap_keep_q & ~rd_end;
            end else if (rd_end) begin
                dp_keep_q <= 1'b0;
            end
        end
    end

    // payload of the pipeline
    always_ff @(posedge clk) begin
        if (wr_issue) begin
            ap_addr_q  <= i_wr_front.addr;
            ap_wdata_q <= i_wr_front.data;
        end else if (rd_issue) begin
            ap_addr_q <= addr_q;
        end
        if (i_hready && ap_valid_q && ap_write_q) begin
            hwdata_q <= ap_wdata_q;
        end
    end

    // chip side handshake
    assign o_dat_rdy = (state_q == ST_CMD) | ((state_q == ST_TO_MEM) & ~i_wr_full);
    assign o_wr_push = wr_acc;
    assign o_wr_beat = '{addr: addr_q, data: i_dat};
    assign o_wr_pop  = wr_issue;

    // an error still ends the beat, the word goes out as zero
    assign o_rd_push  = dp_done & ~dp_write_q & dp_keep_q & ~rd_end & ~i_rd_full;
    assign o_rd_word  = i_hresp ? '0 : i_hrdata;
    assign o_rd_flush = rd_end;

    // byte address is word address times 8
    assign o_haddr  = {{(`CP_HADDR_W-`CP_ADDR_W-3){1'b0}}, ap_addr_q, 3'b000};
    assign o_htrans = !ap_valid_q ? HT_IDLE : (ap_seq_q ? HT_SEQ : HT_NONSEQ);
    assign o_hwrite = ap_write_q;
    assign o_hwdata = hwdata_q;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the chip bridge testbench with verilator and runs it
# exit status is nonzero when the testbench stops on an error
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_chip_bridge \
    -f filelist.f \
    --Mdir obj_dir \
    -o tb_chip_bridge

# stimulus path inside the testbench is relative to this folder
./obj_dir/tb_chip_bridge

// File: test/bridge_input.hex
// record: direction (1 write, 0 read), start word address, count,
// then count words, sent for a write and expected for a read
0000000000000001
0000000000000010
0000000000000005
1111000000000010
2222000000000011
3333000000000012
4444000000000013
5555000000000014
// short read, ended while prefetch runs ahead
0000000000000000
0000000000000012
0000000000000002
3333000000000012
4444000000000013
// overlapping write, ended on its last word
0000000000000001
0000000000000013
0000000000000003
bbbb000000000013
cccc000000000014
dddd000000000015
// full range read back
0000000000000000
0000000000000010
0000000000000006
1111000000000010
2222000000000011
3333000000000012
bbbb000000000013
cccc000000000014
dddd000000000015
ffffffffffffffff

// File: test/tb_chip_bridge_checks.svh
// lfsr source for gaps and back-pressure plus typed compare tasks
// included inside the testbench top module after its signal declarations
`ifndef TB_CHIP_BRIDGE_CHECKS_SVH
`define TB_CHIP_BRIDGE_CHECKS_SVH

// fibonacci lfsr with taps 32 22 2 1 shifting toward the msb
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// one lfsr step per bit handed out
task automatic take_rand_bit(output logic b);
    lfsr_q = lfsr_next(lfsr_q);
    b      = lfsr_q[0];
endtask

// ==================================================
// compare tasks
// ==================================================

// data words seen on the chip port
task automatic check_word(input word_t actual, input word_t expected, input string name);
    if (actual !== expected) begin
        $display("mismatch at %0d ns: %s is %h, expected %h",
                 $time, name, actual, expected);
        fail_run("data word compare failed");
    end
endtask

// single control outputs such as valid and ready
task automatic check_bit(input logic actual, input logic expected, input string name);
    if (actual !== expected) begin
        $display("mismatch at %0d ns: %s is %b, expected %b",
                 $time, name, actual, expected);
        fail_run("control output compare failed");
    end
endtask

`endif

// File: test/tb_chip_bridge.sv
// testbench for the chip port bridge that replays transfers from a hex file
// chip side driven on the falling edge with lfsr gaps and back-pressure
`include "chip_port_params.svh"

module tb_chip_bridge
    import chip_port_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    STIM_LEN        = 64;
    localparam int    CYCLES_PER_WORD = 40;
    localparam word_t END_MARK        = '1;

    logic        clk;
    logic        rst_n;
    logic        i_cmd_vld;
    logic        i_dat_oe;
    word_t       i_dat;
    logic        i_dat_vld;
    logic        o_dat_rdy;
    word_t       o_dat;
    logic        o_dat_vld;
    logic        i_dat_rdy;

    // each record holds direction, start address, count and count words
    word_t       stim [STIM_LEN];
    logic [31:0] lfsr_q        = 32'hf881_4a83;
    int          wd_cycles     = 0;

    task automatic fail_run(input string why);
        $display("error at %0d ns: %s", $time, why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    `include "tb_chip_bridge_checks.svh"

    chip_bridge_top chip_bridge_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_cmd_vld (i_cmd_vld),
        .i_dat_oe  (i_dat_oe),
        .i_dat     (i_dat),
        .i_dat_vld (i_dat_vld),
        .o_dat_rdy (o_dat_rdy),
        .o_dat     (o_dat),
        .o_dat_vld (o_dat_vld),
        .i_dat_rdy (i_dat_rdy)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // armed once the stimulus file is sized
    initial begin : watchdog
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        fail_run("watchdog expired before all transfers finished");
    end

    // ==================================================
    // chip side transfers
    // ==================================================

    // hold cmd_vld until the bridge asks for the command word
    task automatic send_command(input logic dir, input addr_t addr);
        word_t cmd;
        cmd                 = '0;
        cmd[0]              = dir;
        cmd[`CP_ADDR_W:1]   = addr;
        @(negedge clk);
        i_cmd_vld = 1'b1;
        @(negedge clk);
        while (!o_dat_rdy) @(negedge clk);
        i_cmd_vld = 1'b0;
        i_dat_oe  = 1'b1;
        i_dat     = cmd;
        i_dat_vld = 1'b1;
    endtask

    // chip to memory with the end pulse on the last accepted word
    task automatic write_burst(input int base, input int cnt);
        int   idx;
        logic b0;
        logic b1;
        logic rdy;
        idx = 0;
        while (idx < cnt) begin
            @(negedge clk);
            rdy = o_dat_rdy;
            check_bit(o_dat_vld, 1'b0, "o_dat_vld");
            // about one gap in four
            take_rand_bit(b0);
            take_rand_bit(b1);
            i_dat_oe  = 1'b1;
            i_dat_vld = b0 | b1;
            i_dat     = stim[base + idx];
            if ((b0 | b1) && rdy) begin
                if (idx == cnt - 1) begin
                    i_cmd_vld = 1'b1;
                end
                idx++;
            end
        end
        @(negedge clk);
        i_cmd_vld = 1'b0;
        i_dat_vld = 1'b0;
        i_dat_oe  = 1'b0;
        // drain keeps the port closed
        check_bit(o_dat_rdy, 1'b0, "o_dat_rdy");
    endtask

    // memory to chip with ready low about half the time
    task automatic read_burst(input int base, input int cnt);
        int   idx;
        logic take;
        logic vld;
        idx = 0;
        while (idx < cnt) begin
            @(negedge clk);
            vld = o_dat_vld;
            check_bit(o_dat_rdy, 1'b0, "o_dat_rdy");
            take_rand_bit(take);
            i_dat_oe  = 1'b0;
            i_dat_vld = 1'b0;
            i_dat_rdy = take;
            if (take && vld) begin
                check_word(o_dat, stim[base + idx], "o_dat");
                idx++;
            end
        end
        @(negedge clk);
        i_dat_rdy = 1'b0;
        i_cmd_vld = 1'b1;
        @(negedge clk);
        i_cmd_vld = 1'b0;
        // prefetched words are gone after the flush
        check_bit(o_dat_vld, 1'b0, "o_dat_vld");
    endtask

    // ==================================================
    // sequencer
    // ==================================================
    initial begin : sequencer
        int    p;
        int    cnt;
        int    records;
        int    total_words;
        logic  dir;
        addr_t addr;

        rst_n     = 1'b0;
        i_cmd_vld = 1'b0;
        i_dat_oe  = 1'b0;
        i_dat     = '0;
        i_dat_vld = 1'b0;
        i_dat_rdy = 1'b0;

        $readmemh("test/bridge_input.hex", stim);
        // first pass sizes the run
        p           = 0;
        records     = 0;
        total_words = 0;
        while (p < STIM_LEN && stim[p] !== END_MARK) begin
            if (p + 2 >= STIM_LEN || $isunknown(stim[p])) begin
                fail_run("stimulus file is missing or has a broken record");
            end
            cnt = int'(stim[p+2][15:0]);
            total_words = total_words + cnt;
            records++;
            p = p + 3 + cnt;
        end
        if (p >= STIM_LEN) begin
            fail_run("stimulus file has no end marker");
        end
        wd_cycles = (total_words + records) * CYCLES_PER_WORD + 200;

        // reset over two rising edges
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_bit(o_dat_rdy, 1'b0, "o_dat_rdy");
            check_bit(o_dat_vld, 1'b0, "o_dat_vld");
        end

        p = 0;
        while (stim[p] !== END_MARK) begin
            dir  = stim[p][0];
            addr = stim[p+1][`CP_ADDR_W-1:0];
            cnt  = int'(stim[p+2][15:0]);
            send_command(dir, addr);
            if (dir) begin
                write_burst(p + 3, cnt);
            end else begin
                read_burst(p + 3, cnt);
            end
            p = p + 3 + cnt;
            @(negedge clk);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
